/* src/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  // --------------------
  // widths.
  localparam int xlen = 32;

  typedef logic [xlen-1:0] pc_t;
  typedef logic [31:0] inst_t;
  typedef logic [31:0] count_t;

  // --------------------
  // opcode field, bits 6 to 2.
  localparam logic [4:0] opcode_branch = 5'b11000;
  localparam logic [4:0] opcode_jal = 5'b11011;

  // --------------------
  // axi read burst codes.
  localparam logic [2:0] axi_size_word = 3'b010;  // 4 bytes per beat.
  localparam logic [1:0] axi_burst_incr = 2'b01;

endpackage

`default_nettype wire

/* src/fetch_perf.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_perf (
  input  logic               clock,
  input  logic               reset,
  input  logic               out_valid,
  input  logic               out_ready,
  input  logic               refill_done,
  output fetch_pkg::count_t  inst_count,
  output fetch_pkg::count_t  refill_count
);

  logic inst_fire;

  // sticks at all ones.
  function automatic fetch_pkg::count_t sat_inc(input fetch_pkg::count_t c);
    if (&c) begin
      return c;
    end
    return c + 1'b1;
  endfunction

  assign inst_fire = out_valid && out_ready;

  // --------------------
  // event counters.
  always_ff @(posedge clock) begin
    if (reset) begin
      inst_count <= '0;
      refill_count <= '0;
    end else begin
      if (inst_fire) begin
        inst_count <= sat_inc(inst_count);  // delivered beats.
      end
      if (refill_done) begin
        refill_count <= sat_inc(refill_count);  // completed bursts.
      end
    end
  end

endmodule

`default_nettype wire

/* src/icache.sv */
`timescale 1ns/1ns
`default_nettype none

module icache #(
  parameter int line_words = 4,
  parameter int num_lines = 16
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              fencei,
  input  fetch_pkg::pc_t    addr,
  output logic              hit,
  output fetch_pkg::inst_t  inst,
  // axi read address channel.
  output logic              ar_valid,
  input  logic              ar_ready,
  output fetch_pkg::pc_t    ar_addr,
  output logic [7:0]        ar_len,
  output logic [2:0]        ar_size,
  output logic [1:0]        ar_burst,
  // axi read data channel.
  input  logic              r_valid,
  output logic              r_ready,
  input  fetch_pkg::inst_t  r_data,
  input  logic              r_last,
  output logic              refill_done
);

  localparam int off_bits = $clog2(line_words);
  localparam int idx_bits = $clog2(num_lines);
  localparam int line_lsb = off_bits + 2;
  localparam int tag_bits = fetch_pkg::xlen - idx_bits - line_lsb;

  typedef enum logic [1:0] {
    st_idle,
    st_req,
    st_fill
  } state_t;

  state_t state;

  logic [off_bits-1:0] off;
  logic [idx_bits-1:0] idx;
  logic [tag_bits-1:0] tag;

  logic [num_lines-1:0] valid_bits;
  logic [tag_bits-1:0] tag_mem [num_lines];
  fetch_pkg::inst_t data_mem [num_lines*line_words];

  logic [fetch_pkg::xlen-line_lsb-1:0] miss_line;  // {tag, idx} of the line in flight.
  logic [idx_bits-1:0] miss_idx;
  logic [tag_bits-1:0] miss_tag;
  logic [off_bits-1:0] beat;
  logic fence_seen;  // fence.i arrived during refill.
  logic miss;
  logic beat_fire;

  assign off = addr[line_lsb-1:2];
  assign idx = addr[line_lsb +: idx_bits];
  assign tag = addr[fetch_pkg::xlen-1 -: tag_bits];

  assign miss_idx = miss_line[idx_bits-1:0];
  assign miss_tag = miss_line[idx_bits +: tag_bits];

  // --------------------
  // same-cycle lookup.
  assign hit = valid_bits[idx] && (tag_mem[idx] == tag);
  assign inst = data_mem[{idx, off}];

  assign miss = (state == st_idle) && !hit;

  // --------------------
  // bus side.
  assign ar_valid = (state == st_req);
  assign ar_addr = {miss_line, {line_lsb{1'b0}}};
  assign ar_len = 8'(line_words - 1);
  assign ar_size = fetch_pkg::axi_size_word;
  assign ar_burst = fetch_pkg::axi_burst_incr;
  assign r_ready = (state == st_fill);

  assign beat_fire = r_valid && r_ready;
  assign refill_done = beat_fire && r_last;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
      valid_bits <= '0;
      beat <= '0;
      fence_seen <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (miss) begin
            state <= st_req;
            fence_seen <= 1'b0;
            valid_bits[idx] <= 1'b0;  // line gets overwritten.
          end
        end
        st_req: begin
          if (ar_ready) begin
            state <= st_fill;
            beat <= '0;
          end
        end
        st_fill: begin
          if (beat_fire) begin
            beat <= beat + 1'b1;
            if (r_last) begin
              state <= st_idle;
              if (!fence_seen) valid_bits[miss_idx] <= 1'b1;
            end
          end
        end
        default: state <= st_idle;
      endcase
      // flush all lines.
      if (fencei) begin
        valid_bits <= '0;
        if (state != st_idle) fence_seen <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (miss) miss_line <= {tag, idx};
    if (beat_fire) data_mem[{miss_idx, beat}] <= r_data;  // words arrive in order.
    if (refill_done) tag_mem[miss_idx] <= miss_tag;
  end

  // request holds until the slave takes it.
  ar_hold: assert property (@(posedge clock) disable iff (reset)
    (ar_valid && !ar_ready) |=> (ar_valid && $stable(ar_addr)));

endmodule

`default_nettype wire

/* src/ifu.sv */
`timescale 1ns/1ns
`default_nettype none

module ifu #(
  parameter fetch_pkg::pc_t reset_pc = 32'h8000_0000
) (
  input  logic              clock,
  input  logic              reset,
  // redirects.
  input  logic              jump_flush,
  input  fetch_pkg::pc_t    jump_dnpc,
  input  logic              cs_flush,
  input  fetch_pkg::pc_t    cs_dnpc,
  // cache lookup.
  output fetch_pkg::pc_t    fetch_pc,
  input  logic              hit,
  input  fetch_pkg::inst_t  cache_inst,
  // downstream.
  output logic              out_valid,
  input  logic              out_ready,
  output fetch_pkg::pc_t    out_pc,
  output fetch_pkg::inst_t  out_inst
);

  logic flush;
  fetch_pkg::pc_t dnpc;

  logic out_valid_r;
  logic out_valid_r_next;
  fetch_pkg::pc_t out_pc_next;
  fetch_pkg::inst_t out_inst_next;
  fetch_pkg::pc_t fetch_pc_next;

  logic flush_r;  // redirect waiting for a hit.
  logic flush_r_next;
  fetch_pkg::pc_t dnpc_r;
  fetch_pkg::pc_t dnpc_r_next;

  logic out_step_en;

  // cs wins over jump.
  assign flush = jump_flush | cs_flush;
  assign dnpc = cs_flush ? cs_dnpc : jump_dnpc;

  // --------------------
  // static prediction.
  fetch_pkg::pc_t imm_b;
  fetch_pkg::pc_t imm_j;
  fetch_pkg::pc_t pc_incr;
  fetch_pkg::pc_t fetch_pc_pred;

  assign imm_b = {{20{cache_inst[31]}}, cache_inst[7], cache_inst[30:25],
                  cache_inst[11:8], 1'b0};
  assign imm_j = {{12{cache_inst[31]}}, cache_inst[19:12], cache_inst[20],
                  cache_inst[30:21], 1'b0};

  always_comb begin
    case (cache_inst[6:2])
      fetch_pkg::opcode_branch: pc_incr = cache_inst[31] ? imm_b : 32'd4;  // backward only.
      fetch_pkg::opcode_jal:    pc_incr = imm_j;
      default:                  pc_incr = 32'd4;
    endcase
  end

  assign fetch_pc_pred = fetch_pc + pc_incr;

  // --------------------
  // next state.
  assign out_step_en = ~out_valid_r | out_ready;
  assign dnpc_r_next = flush ? dnpc : dnpc_r;

  always_comb begin
    out_valid_r_next = out_valid_r;
    out_pc_next = out_pc;
    out_inst_next = out_inst;
    fetch_pc_next = fetch_pc;
    flush_r_next = flush_r;

    if (flush_r) begin
      if (hit) begin
        flush_r_next = 1'b0;
        fetch_pc_next = dnpc_r;
      end
    end else if (out_step_en) begin
      out_valid_r_next = hit;
      if (hit) begin
        out_pc_next = fetch_pc;
        out_inst_next = cache_inst;
        fetch_pc_next = fetch_pc_pred;
      end
    end

    // redirect drops whatever the stage holds.
    if (flush) begin
      out_valid_r_next = 1'b0;
      if (hit) begin
        fetch_pc_next = dnpc;
      end else begin
        flush_r_next = 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid_r <= 1'b0;
      flush_r <= 1'b0;
      fetch_pc <= reset_pc;
    end else begin
      out_valid_r <= out_valid_r_next;
      flush_r <= flush_r_next;
      fetch_pc <= fetch_pc_next;
    end
  end

  always_ff @(posedge clock) begin
    out_pc <= out_pc_next;
    out_inst <= out_inst_next;
    dnpc_r <= dnpc_r_next;
  end

  assign out_valid = out_valid_r & ~flush;

  // held beat stays put until taken or flushed.
  out_hold: assert property (@(posedge clock) disable iff (reset)
    (out_valid && !out_ready) |=>
      (jump_flush || cs_flush ||
       (out_valid && $stable(out_pc) && $stable(out_inst))));

endmodule

`default_nettype wire

/* src/fetch_top.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_top #(
  parameter fetch_pkg::pc_t reset_pc = 32'h8000_0000,
  parameter int line_words = 4,
  parameter int num_lines = 16
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               jump_flush,
  input  fetch_pkg::pc_t     jump_dnpc,
  input  logic               cs_flush,
  input  fetch_pkg::pc_t     cs_dnpc,
  input  logic               fencei,
  // fetch output.
  output logic               out_valid,
  input  logic               out_ready,
  output fetch_pkg::pc_t     out_pc,
  output fetch_pkg::inst_t   out_inst,
  // axi read.
  output logic               ar_valid,
  input  logic               ar_ready,
  output fetch_pkg::pc_t     ar_addr,
  output logic [7:0]         ar_len,
  output logic [2:0]         ar_size,
  output logic [1:0]         ar_burst,
  input  logic               r_valid,
  output logic               r_ready,
  input  fetch_pkg::inst_t   r_data,
  input  logic               r_last,
  // counters.
  output fetch_pkg::count_t  inst_count,
  output fetch_pkg::count_t  refill_count
);

  fetch_pkg::pc_t fetch_pc;
  fetch_pkg::inst_t cache_inst;
  logic hit;
  logic refill_done;

  ifu #(
    .reset_pc(reset_pc)
  ) u_ifu (
    .clock(clock), .reset(reset),
    .jump_flush(jump_flush), .jump_dnpc(jump_dnpc),
    .cs_flush(cs_flush), .cs_dnpc(cs_dnpc),
    .fetch_pc(fetch_pc), .hit(hit), .cache_inst(cache_inst),
    .out_valid(out_valid), .out_ready(out_ready),
    .out_pc(out_pc), .out_inst(out_inst)
  );

  icache #(
    .line_words(line_words),
    .num_lines(num_lines)
  ) u_icache (
    .clock(clock), .reset(reset), .fencei(fencei),
    .addr(fetch_pc), .hit(hit), .inst(cache_inst),
    .ar_valid(ar_valid), .ar_ready(ar_ready), .ar_addr(ar_addr),
    .ar_len(ar_len), .ar_size(ar_size), .ar_burst(ar_burst),
    .r_valid(r_valid), .r_ready(r_ready), .r_data(r_data), .r_last(r_last),
    .refill_done(refill_done)
  );

  fetch_perf u_perf (
    .clock(clock), .reset(reset),
    .out_valid(out_valid), .out_ready(out_ready), .refill_done(refill_done),
    .inst_count(inst_count), .refill_count(refill_count)
  );

endmodule

`default_nettype wire

/* tb/mem_model.svh */
// model memory holding the 1 KiB program window.
fetch_pkg::inst_t mem [mem_words];
fetch_pkg::pc_t rd_addr;
logic [7:0] rd_left;
logic rd_busy;
logic reset_s;
logic ar_fire;
logic r_fire;

// --------------------
// axi read slave with random stalls on both channels.
initial begin
  ar_ready = 1'b0;
  r_valid = 1'b0;
  r_data = '0;
  r_last = 1'b0;
  rd_busy = 1'b0;
  rd_addr = reset_pc;
  rd_left = '0;
  forever begin
    @(negedge clock);
    reset_s = reset;
    ar_fire = ar_valid && ar_ready;
    r_fire = r_valid && r_ready;
    if (rd_busy && !r_ready) begin
      error_count++;
      $display("ERROR at %0t: r_ready low during a refill burst", $time);
    end
    if (ar_fire) begin
      rd_addr = ar_addr;
      rd_left = ar_len;
      if (ar_addr[31:10] != reset_pc[31:10]) begin
        error_count++;
        $display("ERROR at %0t: burst address %h outside the program window", $time, ar_addr);
      end
      if (ar_len != 8'(line_words - 1) || ar_size != fetch_pkg::axi_size_word ||
          ar_burst != fetch_pkg::axi_burst_incr) begin
        error_count++;
        $display("ERROR at %0t: burst len %0d size %0d type %0d", $time,
                 ar_len, ar_size, ar_burst);
      end
    end
    @(posedge clock);
    #1;
    if (ar_fire) rd_busy = 1'b1;
    if (r_fire) begin
      rd_addr = rd_addr + 32'd4;
      rd_left = rd_left - 8'd1;
      if (r_last) rd_busy = 1'b0;
    end
    if (reset_s) rd_busy = 1'b0;
    ar_ready = !reset_s && !rd_busy && ($urandom % 3 == 0);
    if (!r_valid || r_fire) begin  // a stalled beat holds.
      r_valid = rd_busy && ($urandom % 2 == 0);
      r_data = mem[rd_addr[9:2]];
      r_last = (rd_left == 8'd0);
    end
  end
end

/* tb/fetch_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_tb;

  localparam fetch_pkg::pc_t reset_pc = 32'h8000_0000;
  localparam int line_words = 4;
  localparam int num_lines = 16;
  localparam int mem_words = 256;

  logic clock = 1'b0;
  logic reset;
  logic jump_flush, cs_flush, fencei;
  fetch_pkg::pc_t jump_dnpc, cs_dnpc;
  logic out_valid, out_ready;
  fetch_pkg::pc_t out_pc;
  fetch_pkg::inst_t out_inst;
  logic ar_valid, ar_ready, r_valid, r_ready, r_last;
  fetch_pkg::pc_t ar_addr;
  logic [7:0] ar_len;
  logic [2:0] ar_size;
  logic [1:0] ar_burst;
  fetch_pkg::inst_t r_data;
  fetch_pkg::count_t inst_count, refill_count;

  int error_count = 0;
  int timeout_count = 0;
  int handshakes = 0;
  fetch_pkg::pc_t exp_pc;
  fetch_pkg::pc_t last_pc = reset_pc;  // pc of the last accepted beat.
  fetch_pkg::pc_t succ [mem_words];  // predicted next pc per word.
  bit seen_lines [fetch_pkg::pc_t];
  bit held = 1'b0;
  fetch_pkg::pc_t held_pc;
  fetch_pkg::inst_t held_inst;
  fetch_pkg::count_t refill_at_fence;

  `include "mem_model.svh"

  always #20 clock = ~clock;

  fetch_top #(
    .reset_pc(reset_pc), .line_words(line_words), .num_lines(num_lines)
  ) DUT (
    .clock(clock), .reset(reset),
    .jump_flush(jump_flush), .jump_dnpc(jump_dnpc),
    .cs_flush(cs_flush), .cs_dnpc(cs_dnpc), .fencei(fencei),
    .out_valid(out_valid), .out_ready(out_ready), .out_pc(out_pc), .out_inst(out_inst),
    .ar_valid(ar_valid), .ar_ready(ar_ready), .ar_addr(ar_addr),
    .ar_len(ar_len), .ar_size(ar_size), .ar_burst(ar_burst),
    .r_valid(r_valid), .r_ready(r_ready), .r_data(r_data), .r_last(r_last),
    .inst_count(inst_count), .refill_count(refill_count)
  );

  // --------------------
  // compare tasks.
  task automatic check_pc(input fetch_pkg::pc_t got, input fetch_pkg::pc_t exp, input string what);
    if (got !== exp) begin
      error_count++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_inst(input fetch_pkg::inst_t got, input fetch_pkg::inst_t exp,
                            input string what);
    if (got !== exp) begin
      error_count++;
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input fetch_pkg::count_t got, input fetch_pkg::count_t exp,
                             input bit at_least, input string what);
    if (at_least ? (got < exp) : (got !== exp)) begin
      error_count++;
      $display("ERROR at %0t: %s is %0d, expected %s%0d", $time, what, got,
               at_least ? "at least " : "", exp);
    end
  endtask

  // random word at index i and its predicted successor.
  task automatic place_word(input int i);
    int kind;
    int t;
    logic [12:0] b;
    logic [20:0] j;
    fetch_pkg::inst_t w;
    kind = (i == mem_words - 1) ? 2 : int'($urandom % 8);  // last word jumps back.
    t = int'($urandom % mem_words);
    w = $urandom;
    if (kind == 0 && i > 0) begin
      t = t % i;
      b = 13'((t - i) * 4);
      mem[i] = {b[12], b[10:5], w[24:12], b[4:1], b[11], 7'b1100011};
      succ[i] = reset_pc + 32'(t * 4);
    end else if (kind == 1) begin
      b = 13'(4 * (1 + int'($urandom % 64)));  // forward branches are not taken.
      mem[i] = {b[12], b[10:5], w[24:12], b[4:1], b[11], 7'b1100011};
      succ[i] = reset_pc + 32'((i + 1) * 4);
    end else if (kind == 2) begin
      j = 21'((t - i) * 4);
      mem[i] = {j[20], j[10:1], j[11], j[19:12], w[11:7], 7'b1101111};
      succ[i] = reset_pc + 32'(t * 4);
    end else begin
      mem[i] = {w[31:7], w[0] ? 7'b0010011 : 7'b0110011};
      succ[i] = reset_pc + 32'((i + 1) * 4);
    end
  endtask

  // checks at the falling edge and drives after the rising one.
  task automatic step(input bit flushes);
    bit fl;
    int r;
    @(negedge clock);
    fl = jump_flush || cs_flush;
    if (fl && out_valid) begin
      error_count++;
      $display("ERROR at %0t: out_valid high in a flush cycle", $time);
    end
    if (held && !fl) begin
      if (!out_valid) begin
        error_count++;
        $display("ERROR at %0t: out_valid dropped under back-pressure", $time);
      end
      check_pc(out_pc, held_pc, "held out_pc");
      check_inst(out_inst, held_inst, "held out_inst");
    end
    if (out_valid && out_ready) begin
      check_pc(out_pc, exp_pc, "out_pc");
      check_inst(out_inst, mem[exp_pc[9:2]], "out_inst");
      seen_lines[exp_pc / (line_words * 4)] = 1'b1;
      last_pc = exp_pc;
      exp_pc = succ[exp_pc[9:2]];
      handshakes++;
    end
    held = out_valid && !out_ready;
    held_pc = out_pc;
    held_inst = out_inst;
    if (fl) exp_pc = cs_flush ? cs_dnpc : jump_dnpc;  // cs wins.
    @(posedge clock);
    #1;
    out_ready = ($urandom % 4 != 0);
    r = flushes ? int'($urandom % 24) : 3;
    jump_flush = (r == 0 || r == 2);
    cs_flush = (r == 1 || r == 2);
    jump_dnpc = reset_pc + 32'(($urandom % mem_words) * 4);
    cs_dnpc = reset_pc + 32'(($urandom % mem_words) * 4);
    fencei = 1'b0;
  endtask

  task automatic wait_beats(input int count);
    int target;
    int n;
    target = handshakes + count;
    n = 0;
    while (handshakes < target && n < 2000) begin
      step(1'b0);
      n++;
    end
    if (handshakes < target) begin
      timeout_count++;
      $display("timeout: fewer than %0d fetch beats arrived within 2000 cycles", count);
    end
  endtask

  // rewrite the line fetched last and redirect onto it under fence.i.
  task automatic fence_rewrite();
    int base;
    base = int'(last_pc[9:2]) & ~(line_words - 1);
    if (base > mem_words - 8) begin
      base = mem_words - 8;
    end
    for (int k = 0; k < 8; k++) begin
      place_word(base + k);
    end
    refill_at_fence = refill_count;
    fencei = 1'b1;
    cs_flush = 1'b1;
    cs_dnpc = reset_pc + 32'(base * 4);
  endtask

  initial begin
    void'($urandom(17));
    reset = 1'b1;
    jump_flush = 1'b0;
    cs_flush = 1'b0;
    fencei = 1'b0;
    out_ready = 1'b0;
    jump_dnpc = reset_pc;
    cs_dnpc = reset_pc;
    for (int i = 0; i < mem_words; i++) begin
      place_word(i);
    end
    exp_pc = reset_pc;
    repeat (16) @(posedge clock);
    #1 reset = 1'b0;

    wait_beats(1);  // first beat must come from reset_pc.
    repeat (300) step(1'b0);
    repeat (600) step(1'b1);
    wait_beats(4);
    for (int f = 0; f < 3; f++) begin
      fence_rewrite();
      wait_beats(12);
      repeat (100) step(1'b1);
    end
    wait_beats(4);

    // --------------------
    // drain and compare the counters.
    out_ready = 1'b0;
    jump_flush = 1'b0;
    cs_flush = 1'b0;
    repeat (3) @(posedge clock);
    #1;
    check_count(inst_count, fetch_pkg::count_t'(handshakes), 1'b0, "inst_count");
    check_count(refill_count, fetch_pkg::count_t'(seen_lines.num()), 1'b1, "refill_count");
    check_count(refill_count, refill_at_fence + 32'd1, 1'b1, "refill_count after fence.i");

    $display("errors: %0d mismatches, %0d timeouts, %0d beats checked",
             error_count, timeout_count, handshakes);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+tb
src/fetch_pkg.sv
src/fetch_perf.sv
src/icache.sv
src/ifu.sv
src/fetch_top.sv
tb/fetch_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module fetch_tb -f all.f -o fetch_sim
./obj_dir/fetch_sim | tee sim.log

if grep -qx "Test completed successfully" sim.log; then
  echo "run.sh: simulation passed"
else
  echo "run.sh: simulation did not pass, see sim.log"
  exit 1
fi
